// ==== Makefile ====
# Verilator flow for the RV32I subset core with AHB-Lite masters

VERILATOR ?= verilator
TOP       ?= tb_rv_core
VFLAGS    ?= --timing --assert
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# grep decides pass or fail from the simulation output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+src
src/rv_core_pkg.sv
src/rv_ahb_master.sv
src/rv_sequencer.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_ahb.sv
verification/tb_rv_core.sv

// ==== src/rv_ahb_master.sv ====
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_ahb_master import rv_core_pkg::*; (
  input  logic       HCLK,
  input  logic       reset_i,
  input  logic       start_i,
  input  word_t      addr_i,
  input  logic       write_i,
  input  word_t      wdata_i,
  output logic       done_o,
  output word_t      rdata_o,
  output logic       err_o,
  output word_t      haddr_o,
  output logic [1:0] htrans_o,
  output logic       hwrite_o,
  output word_t      hwdata_o,
  input  word_t      hrdata_i,
  input  logic       hready_i,
  input  logic       hresp_i
);

  ahb_state_e state_q;
  word_t      addr_q;
  word_t      wdata_q;
  word_t      rdata_q;
  logic       write_q;
  logic       launch;

  // Address phase opens in the same cycle as the start strobe
  assign launch = (state_q == B_IDLE) && start_i;

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      state_q <= B_IDLE;
    end else begin
      case (state_q)
        B_IDLE:  if (start_i) state_q <= hready_i ? B_DATA : B_ADDR;
        B_ADDR:  if (hready_i) state_q <= B_DATA;
        B_DATA:  if (hready_i) state_q <= B_IDLE;
        default: state_q <= B_IDLE;
      endcase
    end
  end

  always_ff @(posedge HCLK) begin
    if (launch) begin
      addr_q  <= addr_i;
      write_q <= write_i;
      wdata_q <= wdata_i;
    end
    if (done_o) begin
      rdata_q <= hrdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////
  // Latched copies hold address and control stable through wait states
  assign htrans_o = (launch || state_q == B_ADDR) ? `RV_HTRANS_NONSEQ : `RV_HTRANS_IDLE;
  assign haddr_o  = launch ? addr_i : addr_q;
  assign hwrite_o = launch ? write_i : write_q;
  assign hwdata_o = wdata_q;

  // Completion in the last data phase cycle
  assign done_o  = (state_q == B_DATA) && hready_i;
  assign err_o   = done_o && hresp_i;
  assign rdata_o = rdata_q;

endmodule

// ==== src/rv_core_ahb.sv ====
`timescale 1ns/100ps

module rv_core_ahb import rv_core_pkg::*; (
  input  logic       HCLK,
  input  logic       reset_i,
  output word_t      ins_haddr_o,
  output logic [1:0] ins_htrans_o,
  input  word_t      ins_hrdata_i,
  input  logic       ins_hready_i,
  input  logic       ins_hresp_i,
  output word_t      dat_haddr_o,
  output logic [1:0] dat_htrans_o,
  output logic       dat_hwrite_o,
  output word_t      dat_hwdata_o,
  input  word_t      dat_hrdata_i,
  input  logic       dat_hready_i,
  input  logic       dat_hresp_i,
  output logic       halted_o
);

  // Sequencer handshakes
  logic      ifetch_start;
  logic      ifetch_done;
  logic      ifetch_err;
  logic      mem_start;
  logic      mem_done;
  logic      mem_err;
  logic      decode_en;
  logic      exec_en;
  logic      wb_en;
  word_t     pc;
  word_t     next_pc;

  // Datapath
  word_t     instr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     op_a;
  word_t     op_b;
  word_t     store_data;
  word_t     imm;
  alu_op_e   alu_op;
  opcode_e   opcode;
  logic      branch_ne;
  logic      reg_write;
  logic      is_mem;
  logic      is_illegal;
  logic      is_halt;
  word_t     alu_result;
  word_t     link;
  word_t     load_data;

  //////////////////////////////////////////////////
  // Core
  //////////////////////////////////////////////////
  rv_sequencer sequencer (
    .HCLK (HCLK), .reset_i (reset_i),
    .ifetch_done_i (ifetch_done), .ifetch_err_i (ifetch_err),
    .mem_done_i (mem_done), .mem_err_i (mem_err),
    .is_mem_i (is_mem), .is_illegal_i (is_illegal), .is_halt_i (is_halt),
    .next_pc_i (next_pc), .ifetch_start_o (ifetch_start), .mem_start_o (mem_start),
    .pc_o (pc), .decode_en_o (decode_en), .exec_en_o (exec_en), .wb_en_o (wb_en),
    .halted_o (halted_o)
  );

  rv_decode decode (
    .HCLK (HCLK), .reset_i (reset_i), .decode_en_i (decode_en),
    .instr_i (instr), .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr), .rd_addr_o (rd_addr),
    .op_a_o (op_a), .op_b_o (op_b), .store_data_o (store_data), .imm_o (imm),
    .alu_op_o (alu_op), .opcode_o (opcode), .branch_ne_o (branch_ne),
    .reg_write_o (reg_write), .is_mem_o (is_mem),
    .is_illegal_o (is_illegal), .is_halt_o (is_halt)
  );

  rv_execute execute (
    .HCLK (HCLK), .reset_i (reset_i), .exec_en_i (exec_en), .pc_i (pc),
    .op_a_i (op_a), .op_b_i (op_b), .imm_i (imm), .alu_op_i (alu_op),
    .opcode_i (opcode), .branch_ne_i (branch_ne),
    .alu_result_o (alu_result), .next_pc_o (next_pc), .link_o (link)
  );

  rv_result result (
    .HCLK (HCLK), .reset_i (reset_i), .wb_en_i (wb_en),
    .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr), .rd_addr_i (rd_addr),
    .reg_write_i (reg_write), .opcode_i (opcode), .alu_result_i (alu_result),
    .load_data_i (load_data), .link_i (link),
    .rs1_data_o (rs1_data), .rs2_data_o (rs2_data)
  );

  //////////////////////////////////////////////////
  // Bus masters
  //////////////////////////////////////////////////
  // Instruction side only reads
  rv_ahb_master ins_master (
    .HCLK (HCLK), .reset_i (reset_i),
    .start_i (ifetch_start), .addr_i (pc), .write_i (1'b0), .wdata_i ('0),
    .done_o (ifetch_done), .rdata_o (instr), .err_o (ifetch_err),
    .haddr_o (ins_haddr_o), .htrans_o (ins_htrans_o), .hwrite_o (), .hwdata_o (),
    .hrdata_i (ins_hrdata_i), .hready_i (ins_hready_i), .hresp_i (ins_hresp_i)
  );

  rv_ahb_master dat_master (
    .HCLK (HCLK), .reset_i (reset_i),
    .start_i (mem_start), .addr_i (alu_result), .write_i (opcode == OPC_STORE),
    .wdata_i (store_data), .done_o (mem_done), .rdata_o (load_data), .err_o (mem_err),
    .haddr_o (dat_haddr_o), .htrans_o (dat_htrans_o),
    .hwrite_o (dat_hwrite_o), .hwdata_o (dat_hwdata_o),
    .hrdata_i (dat_hrdata_i), .hready_i (dat_hready_i), .hresp_i (dat_hresp_i)
  );

endmodule

// ==== src/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Datapath and register file sizes
`define RV_XLEN        32
`define RV_REG_COUNT   32
`define RV_REG_ADDR_W  5

// Program counter out of reset
`define RV_PC_INIT     32'h0000_0200

// HTRANS codes in use, no bursts so SEQ and BUSY never appear
`define RV_HTRANS_IDLE   2'b00
`define RV_HTRANS_NONSEQ 2'b10

`endif

// ==== src/rv_core_pkg.sv ====
`include "rv_core_consts.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]       word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // One instruction at a time
  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_MEM,
    S_WRITEBACK,
    S_HALT
  } seq_state_e;

  typedef enum logic [1:0] {
    B_IDLE,
    B_ADDR,
    B_DATA
  } ahb_state_e;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode import rv_core_pkg::*; (
  input  logic      HCLK,
  input  logic      reset_i,
  input  logic      decode_en_i,
  input  word_t     instr_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output reg_addr_t rd_addr_o,
  output word_t     op_a_o,
  output word_t     op_b_o,
  output word_t     store_data_o,
  output word_t     imm_o,
  output alu_op_e   alu_op_o,
  output opcode_e   opcode_o,
  output logic      branch_ne_o,
  output logic      reg_write_o,
  output logic      is_mem_o,
  output logic      is_illegal_o,
  output logic      is_halt_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  word_t      imm;
  alu_op_e    alu_op;
  logic       use_imm;
  logic       reg_write;
  logic       illegal;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  // Register file is read straight from the fetched word during decode
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  always_comb begin
    imm       = {{20{instr_i[31]}}, instr_i[31:20]};
    alu_op    = ALU_ADD;
    use_imm   = 1'b1;
    reg_write = 1'b1;
    illegal   = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        use_imm = (opcode == OPC_OP_IMM);
        case (funct3)
          3'b000: alu_op = (!use_imm && instr_i[30]) ? ALU_SUB : ALU_ADD;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          // SLT only in register form
          3'b010: begin
            alu_op  = ALU_SLT;
            illegal = use_imm;
          end
          default: illegal = 1'b1;
        endcase
      end
      OPC_LUI: begin
        imm    = {instr_i[31:12], 12'b0};
        alu_op = ALU_PASS_B;
      end
      OPC_LOAD: illegal = (funct3 != 3'b010);
      OPC_STORE: begin
        imm       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        reg_write = 1'b0;
        illegal   = (funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        imm       = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                     instr_i[30:25], instr_i[11:8], 1'b0};
        use_imm   = 1'b0;
        reg_write = 1'b0;
        illegal   = (funct3[2:1] != 2'b00);
      end
      OPC_JAL: begin
        imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
               instr_i[20], instr_i[30:21], 1'b0};
      end
      // Only EBREAK is accepted
      OPC_SYSTEM: begin
        reg_write = 1'b0;
        illegal   = (instr_i[31:7] != 25'h0002000);
      end
      default: begin
        reg_write = 1'b0;
        illegal   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      reg_write_o  <= 1'b0;
      is_mem_o     <= 1'b0;
      is_illegal_o <= 1'b0;
      is_halt_o    <= 1'b0;
    end else if (decode_en_i) begin
      reg_write_o  <= reg_write;
      is_mem_o     <= (opcode == OPC_LOAD) || (opcode == OPC_STORE);
      is_illegal_o <= illegal;
      is_halt_o    <= (opcode == OPC_SYSTEM) && !illegal;
    end
  end

  // Operands and fields for execute and writeback
  always_ff @(posedge HCLK) begin
    if (decode_en_i) begin
      rd_addr_o    <= instr_i[11:7];
      op_a_o       <= rs1_data_i;
      op_b_o       <= use_imm ? imm : rs2_data_i;
      store_data_o <= rs2_data_i;
      imm_o        <= imm;
      alu_op_o     <= alu_op;
      opcode_o     <= opcode;
      branch_ne_o  <= funct3[0];
    end
  end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_execute import rv_core_pkg::*; (
  input  logic    HCLK,
  input  logic    reset_i,
  input  logic    exec_en_i,
  input  word_t   pc_i,
  input  word_t   op_a_i,
  input  word_t   op_b_i,
  input  word_t   imm_i,
  input  alu_op_e alu_op_i,
  input  opcode_e opcode_i,
  input  logic    branch_ne_i,
  output word_t   alu_result_o,
  output word_t   next_pc_o,
  output word_t   link_o
);

  word_t alu_out;
  logic  taken;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_out = op_a_i + op_b_i;
      ALU_SUB:    alu_out = op_a_i - op_b_i;
      ALU_AND:    alu_out = op_a_i & op_b_i;
      ALU_OR:     alu_out = op_a_i | op_b_i;
      ALU_XOR:    alu_out = op_a_i ^ op_b_i;
      ALU_SLT:    alu_out = word_t'($signed(op_a_i) < $signed(op_b_i));
      ALU_PASS_B: alu_out = op_b_i;
      default:    alu_out = op_a_i + op_b_i;
    endcase
  end

  // BEQ or BNE picked by funct3 bit 0, JAL always jumps
  assign taken = (opcode_i == OPC_JAL) ||
                 ((opcode_i == OPC_BRANCH) && ((op_a_i == op_b_i) != branch_ne_i));

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      next_pc_o <= `RV_PC_INIT;
    end else if (exec_en_i) begin
      next_pc_o <= taken ? pc_i + imm_i : pc_i + 32'd4;
    end
  end

  // ALU result doubles as the LW/SW address
  always_ff @(posedge HCLK) begin
    if (exec_en_i) begin
      alu_result_o <= alu_out;
      link_o       <= pc_i + 32'd4;
    end
  end

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_result import rv_core_pkg::*; (
  input  logic      HCLK,
  input  logic      reset_i,
  input  logic      wb_en_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  reg_addr_t rd_addr_i,
  input  logic      reg_write_i,
  input  opcode_e   opcode_i,
  input  word_t     alu_result_i,
  input  word_t     load_data_i,
  input  word_t     link_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  // x0 has no storage
  word_t regs [1:`RV_REG_COUNT-1];
  word_t wb_data;

  always_comb begin
    case (opcode_i)
      OPC_LOAD: wb_data = load_data_i;
      OPC_JAL:  wb_data = link_i;
      default:  wb_data = alu_result_i;
    endcase
  end

  // Registers start at zero
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      for (int i = 1; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && reg_write_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= wb_data;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== src/rv_sequencer.sv ====
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_sequencer import rv_core_pkg::*; (
  input  logic  HCLK,
  input  logic  reset_i,
  input  logic  ifetch_done_i,
  input  logic  ifetch_err_i,
  input  logic  mem_done_i,
  input  logic  mem_err_i,
  input  logic  is_mem_i,
  input  logic  is_illegal_i,
  input  logic  is_halt_i,
  input  word_t next_pc_i,
  output logic  ifetch_start_o,
  output logic  mem_start_o,
  output word_t pc_o,
  output logic  decode_en_o,
  output logic  exec_en_o,
  output logic  wb_en_o,
  output logic  halted_o
);

  seq_state_e state_q;
  seq_state_e state_d;
  word_t      pc_q;
  logic       run_q;
  logic       busy_q;
  logic       bus_go;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FETCH: begin
        if (ifetch_done_i) begin
          state_d = ifetch_err_i ? S_HALT : S_DECODE;
        end
      end
      S_DECODE: state_d = S_EXECUTE;
      // Decoded flags are valid from here on
      S_EXECUTE: begin
        if (is_illegal_i || is_halt_i) begin
          state_d = S_HALT;
        end else begin
          state_d = is_mem_i ? S_MEM : S_WRITEBACK;
        end
      end
      S_MEM: begin
        if (mem_done_i) begin
          state_d = mem_err_i ? S_HALT : S_WRITEBACK;
        end
      end
      S_WRITEBACK: state_d = S_FETCH;
      default: state_d = S_HALT;
    endcase
  end

  // run_q keeps both buses idle while reset is applied
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      state_q <= S_FETCH;
      pc_q    <= `RV_PC_INIT;
      run_q   <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      run_q   <= 1'b1;
      if (wb_en_o) begin
        pc_q <= next_pc_i;
      end
      if (ifetch_start_o || mem_start_o) begin
        busy_q <= 1'b1;
      end else if (ifetch_done_i || mem_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // One start per bus request, the next only after done
  assign bus_go         = run_q && !busy_q;
  assign ifetch_start_o = (state_q == S_FETCH) && bus_go;
  assign mem_start_o    = (state_q == S_MEM) && bus_go;

  assign decode_en_o = (state_q == S_DECODE);
  assign exec_en_o   = (state_q == S_EXECUTE);
  assign wb_en_o     = (state_q == S_WRITEBACK);
  assign halted_o    = (state_q == S_HALT);
  assign pc_o        = pc_q;

endmodule

// ==== verification/tb_rv_core.sv ====
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module tb_rv_core;

  localparam logic [31:0] DBASE = 32'h0000_1000;

  logic        HCLK;
  logic        reset_i;
  logic [31:0] ins_haddr_o, ins_hrdata_i, dat_haddr_o, dat_hwdata_o, dat_hrdata_i;
  logic [1:0]  ins_htrans_o, dat_htrans_o;
  logic        ins_hready_i, ins_hresp_i, dat_hwrite_o, dat_hready_i, dat_hresp_i;
  logic        halted_o;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [31:0] ref_dmem [64];
  logic [31:0] ref_regs [32];
  logic [31:0] exp_pc[$], exp_wa[$], exp_wd[$];
  logic [31:0] pc_q[$], wa_q[$], wd_q[$];
  logic [31:0] i_addr, d_addr;
  logic        i_dph, d_dph, d_wr, wait_mode, err_mode, err_seen;
  int          i_wait, d_wait, seed, errors, test_base, tests_run, tests_failed, n_prog;
  string       cur_test;

  rv_core_ahb DUT (.*);

  always #20 HCLK = ~HCLK;

  //////////////////////////////////////////////////
  // Program and reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] r_op(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction

  function automatic logic [31:0] i_op(logic [11:0] im, int rs1, logic [2:0] f3, int rd,
                                        logic [6:0] opc);
    return {im, 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] s_op(logic [11:0] im, int rs2, int rs1);
    return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_op(logic [12:0] im, int rs2, int rs1, logic [2:0] f3);
    return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_op(logic [20:0] im, int rd);
    return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'h6f};
  endfunction

  task automatic put(logic [31:0] ins);
    imem[n_prog] = ins;
    n_prog++;
  endtask

  task automatic build_program();
    for (int i = 0; i < 64; i++) imem[i] = 32'h0010_0073;
    n_prog = 0;
    put({20'h00001, 5'd10, 7'h37});                // x10 = data base
    put(i_op(12'h123, 0, 3'b000, 1, 7'h13));
    put(i_op(12'hffb, 0, 3'b000, 2, 7'h13));
    put(r_op(7'h00, 2, 1, 3'b000, 3));
    put(s_op(12'd0, 3, 10));
    put(r_op(7'h20, 2, 1, 3'b000, 4));
    put(s_op(12'd4, 4, 10));
    put(r_op(7'h00, 2, 1, 3'b111, 5));
    put(s_op(12'd8, 5, 10));
    put(r_op(7'h00, 2, 1, 3'b110, 6));
    put(s_op(12'd12, 6, 10));
    put(r_op(7'h00, 2, 1, 3'b100, 7));
    put(s_op(12'd16, 7, 10));
    put(r_op(7'h00, 1, 2, 3'b010, 8));
    put(s_op(12'd20, 8, 10));
    put(i_op(12'h0f0, 1, 3'b100, 9, 7'h13));
    put(s_op(12'd24, 9, 10));
    put(i_op(12'h07f, 2, 3'b111, 12, 7'h13));
    put(i_op(12'hf00, 12, 3'b110, 12, 7'h13));
    put(s_op(12'd28, 12, 10));
    put(i_op(12'h005, 1, 3'b000, 0, 7'h13));       // write to x0 is dropped
    put(s_op(12'd32, 0, 10));
    put({20'habcde, 5'd13, 7'h37});
    put(s_op(12'd36, 13, 10));
    put(i_op(12'h040, 10, 3'b010, 14, 7'h03));
    put(s_op(12'd40, 14, 10));
    put(b_op(13'd8, 1, 1, 3'b000));                // taken BEQ skips a store
    put(s_op(12'd44, 1, 10));
    put(b_op(13'd8, 1, 1, 3'b001));                // BNE falls through
    put(s_op(12'd48, 2, 10));
    put(j_op(21'd8, 15));
    put(s_op(12'd52, 0, 10));
    put(s_op(12'd56, 15, 10));
    put(32'h0010_0073);
  endtask

  task automatic preload_data();
    for (int i = 0; i < 64; i++) begin
      dmem[i] = ~(DBASE + 32'(4 * i)) ^ 32'h1357_9bdf;
    end
  endtask

  // ISA-level interpreter giving fetch and store order
  task automatic run_reference();
    logic [31:0] pc, ins, a, b, res, immb, immj;
    logic [6:0]  opc;
    logic [2:0]  f3;
    pc = `RV_PC_INIT;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    for (int i = 0; i < 64; i++) ref_dmem[i] = dmem[i];
    for (int step = 0; step < 200; step++) begin
      ins  = imem[((pc - `RV_PC_INIT) >> 2) & 63];
      opc  = ins[6:0];
      f3   = ins[14:12];
      a    = ref_regs[ins[19:15]];
      b    = (opc == 7'h33) ? ref_regs[ins[24:20]] : sext12(ins[31:20]);
      immb = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      immj = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      exp_pc.push_back(pc);
      if (opc == 7'h73) break;
      case (f3)
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
        default: res = (opc == 7'h33 && ins[30]) ? a - b : a + b;
      endcase
      case (opc)
        7'h37: ref_regs[ins[11:7]] = {ins[31:12], 12'b0};
        7'h03: ref_regs[ins[11:7]] = ref_dmem[((a + b - DBASE) >> 2) & 63];
        7'h23: begin
          res = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          exp_wa.push_back(res);
          exp_wd.push_back(ref_regs[ins[24:20]]);
          ref_dmem[((res - DBASE) >> 2) & 63] = ref_regs[ins[24:20]];
        end
        7'h6f: ref_regs[ins[11:7]] = pc + 32'd4;
        7'h63: ;
        default: ref_regs[ins[11:7]] = res;
      endcase
      ref_regs[0] = '0;
      if (opc == 7'h6f) pc = pc + immj;
      else if (opc == 7'h63 && ((a == ref_regs[ins[24:20]]) != f3[0])) pc = pc + immb;
      else pc = pc + 32'd4;
    end
  endtask

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////
  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("Fail %s: %s expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic note_error(string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic abort_on_timeout(string what);
    $display("Timeout in %s while waiting for %s", cur_test, what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic begin_test(string name);
    cur_test  = name;
    test_base = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_base) begin
      $display("%s passed", cur_test);
    end else begin
      tests_failed++;
      $display("%s had %0d errors", cur_test, errors - test_base);
    end
  endtask

  task automatic apply_reset();
    @(posedge HCLK);
    #2 reset_i = 1'b1;
    preload_data();
    pc_q = exp_pc;
    wa_q = exp_wa;
    wd_q = exp_wd;
    err_seen = 1'b0;
    repeat (4) @(posedge HCLK);
    #2 reset_i = 1'b0;
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    while (!halted_o && n < 3000) begin
      @(negedge HCLK);
      n++;
    end
    if (!halted_o) abort_on_timeout("halted_o");
  endtask

  //////////////////////////////////////////////////
  // AHB-Lite memory models
  //////////////////////////////////////////////////
  // Bus responses chosen at negedge apply from the next rising edge
  always @(negedge HCLK) begin
    if (reset_i) begin
      i_dph  = 1'b0;
      d_dph  = 1'b0;
      i_wait = 0;
      d_wait = 0;
    end else begin
      if (i_dph && ins_hready_i) i_dph = 1'b0;
      if (ins_htrans_o == `RV_HTRANS_NONSEQ && ins_hready_i) begin
        i_dph  = 1'b1;
        i_addr = ins_haddr_o;
        if (pc_q.size() == 0) note_error("fetch beyond the expected program");
        else check_value("fetch address", pc_q.pop_front(), ins_haddr_o);
      end
      if (d_dph && dat_hready_i) begin
        d_dph = 1'b0;
        if (d_wr) begin
          if (wa_q.size() == 0) begin
            note_error("data write beyond the expected sequence");
          end else begin
            check_value("write address", wa_q.pop_front(), d_addr);
            check_value("write data", wd_q.pop_front(), dat_hwdata_o);
          end
          if (dat_hresp_i) err_seen = 1'b1;
          else dmem[((d_addr - DBASE) >> 2) & 63] = dat_hwdata_o;
        end
      end
      if (dat_htrans_o == `RV_HTRANS_NONSEQ && dat_hready_i) begin
        d_dph  = 1'b1;
        d_addr = dat_haddr_o;
        d_wr   = dat_hwrite_o;
      end
      if (wait_mode && ins_hready_i) i_wait = $unsigned($random(seed)) % 4;
      if (wait_mode && dat_hready_i) d_wait = $unsigned($random(seed)) % 4;
    end
  end

  always @(posedge HCLK) begin
    #2;
    ins_hready_i = (i_wait == 0);
    dat_hready_i = (d_wait == 0);
    if (i_wait > 0) i_wait--;
    if (d_wait > 0) d_wait--;
    ins_hrdata_i = imem[((i_addr - `RV_PC_INIT) >> 2) & 63];
    dat_hrdata_i = dmem[((d_addr - DBASE) >> 2) & 63];
    dat_hresp_i  = err_mode && d_dph && d_wr;
  end

  //////////////////////////////////////////////////
  // Concurrent checks
  //////////////////////////////////////////////////
  a_reset_idle: assert property (@(negedge HCLK) reset_i && $past(reset_i) |->
      ins_htrans_o == `RV_HTRANS_IDLE && dat_htrans_o == `RV_HTRANS_IDLE && !halted_o)
    else note_error("bus active or halted_o high during reset");

  a_halt_idle: assert property (@(negedge HCLK) disable iff (reset_i) halted_o |->
      ins_htrans_o == `RV_HTRANS_IDLE && dat_htrans_o == `RV_HTRANS_IDLE)
    else note_error("transfer started while the core is halted");

  a_ins_hold: assert property (@(negedge HCLK) disable iff (reset_i)
      ins_htrans_o == `RV_HTRANS_NONSEQ && !ins_hready_i |=>
      ins_htrans_o == `RV_HTRANS_NONSEQ && $stable(ins_haddr_o))
    else note_error("instruction address phase changed during a wait state");

  a_dat_hold: assert property (@(negedge HCLK) disable iff (reset_i)
      dat_htrans_o == `RV_HTRANS_NONSEQ && !dat_hready_i |=>
      dat_htrans_o == `RV_HTRANS_NONSEQ && $stable(dat_haddr_o) && $stable(dat_hwrite_o))
    else note_error("data address phase changed during a wait state");

  a_wdata_hold: assert property (@(negedge HCLK) disable iff (reset_i)
      d_dph && d_wr && !dat_hready_i |=> $stable(dat_hwdata_o))
    else note_error("write data changed during a wait state");

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    int n;
    HCLK = 1'b0;
    reset_i = 1'b1;
    ins_hrdata_i = '0;
    ins_hready_i = 1'b1;
    ins_hresp_i = 1'b0;
    dat_hrdata_i = '0;
    dat_hready_i = 1'b1;
    dat_hresp_i = 1'b0;
    i_addr = `RV_PC_INIT;
    d_addr = DBASE;
    d_wr = 1'b0;
    seed = 76;
    wait_mode = 1'b0;
    err_mode = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    build_program();
    preload_data();
    run_reference();

    begin_test("reset and first fetch");
    apply_reset();
    n = 0;
    while (ins_htrans_o != `RV_HTRANS_NONSEQ && n < 20) begin
      @(negedge HCLK);
      n++;
    end
    if (ins_htrans_o != `RV_HTRANS_NONSEQ) abort_on_timeout("the first fetch");
    check_value("first fetch", `RV_PC_INIT, ins_haddr_o);
    end_test();

    begin_test("program zero wait");
    wait_halt();
    if (wa_q.size() != 0) note_error("expected data writes never appeared");
    check_value("loaded word", dmem[16], dmem[10]);
    end_test();

    begin_test("ebreak halt");
    repeat (10) @(negedge HCLK);
    check_value("halted_o", 32'd1, {31'b0, halted_o});
    if (pc_q.size() != 0) note_error("expected fetches never appeared");
    end_test();

    begin_test("program wait states");
    wait_mode = 1'b1;
    apply_reset();
    wait_halt();
    if (wa_q.size() != 0) note_error("expected data writes never appeared");
    check_value("loaded word", dmem[16], dmem[10]);
    end_test();

    begin_test("bus error halt");
    wait_mode = 1'b0;
    err_mode  = 1'b1;
    apply_reset();
    wait_halt();
    if (!err_seen) note_error("core halted without an error response");
    // The first store gets the error, so nothing follows it
    check_value("writes before halt", 32'd1, 32'(exp_wa.size() - wa_q.size()));
    repeat (5) @(negedge HCLK);
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
